// ==== common/rvPkg.sv ====
package rvPkg;

	localparam int XLEN = 32;
	localparam int ADDR_W = 12; // I-mem byte address, D-mem word address
	localparam int REG_W = 5;

	// Major opcodes, inst[6:0]
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [XLEN-1:0] INST_EBREAK = 32'h0010_0073;

	typedef enum logic [3:0] {
		OP,
		OP_IMM,
		LUI,
		AUIPC,
		JAL,
		JALR,
		BRANCH,
		LOAD,
		STORE,
		HALT,
		ILLEGAL
	} instClass_e;

	typedef enum logic [4:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		BEQ, BNE, BLT, BGE, BLTU, BGEU
	} aluOp_e;

	typedef struct packed {
		instClass_e instClass;
		aluOp_e aluOp;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0] imm; // Sign-extended per format
		logic useImm; // Operand B is imm, not rs2
		logic writesRd;
	} decodedInst_t;

	typedef struct packed {
		logic [ADDR_W-1:0] seqPc;
		logic [ADDR_W-1:0] relPc;
		logic [ADDR_W-1:0] jalrPc;
	} pcTargets_t;

	typedef struct packed {
		logic [XLEN-1:0] value;
		logic taken;
	} aluResult_t;

endpackage

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder import rvPkg::*; (
	input logic [XLEN-1:0] inst,
	output decodedInst_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [XLEN-1:0] immI, immS, immB, immU, immJ;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	function automatic aluOp_e arithOp(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: arithOp = alt ? SUB : ADD;
			3'b001: arithOp = SLL;
			3'b010: arithOp = SLT;
			3'b011: arithOp = SLTU;
			3'b100: arithOp = XOR;
			3'b101: arithOp = alt ? SRA : SRL;
			3'b110: arithOp = OR;
			default: arithOp = AND;
		endcase
	endfunction

	function automatic aluOp_e branchOp(input logic [2:0] f3);
		case (f3)
			3'b000: branchOp = BEQ;
			3'b001: branchOp = BNE;
			3'b100: branchOp = BLT;
			3'b101: branchOp = BGE;
			3'b110: branchOp = BLTU;
			default: branchOp = BGEU;
		endcase
	endfunction

	always_comb begin
		dec.instClass = ILLEGAL; // No-op unless matched below
		dec.aluOp = ADD;
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.rd = inst[11:7];
		dec.imm = immI;
		dec.useImm = 1'b1;
		dec.writesRd = 1'b0;
		case (opcode)
			OPC_OP: begin
				if (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101})) begin
					dec.instClass = OP;
					dec.aluOp = arithOp(funct3, funct7[5]);
					dec.useImm = 1'b0;
					dec.writesRd = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				// Shift immediates carry funct7, the rest do not
				if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'b0 ||
						(funct3 == 3'b101 && funct7 == 7'b0100000)) begin
					dec.instClass = OP_IMM;
					dec.aluOp = arithOp(funct3, funct3 == 3'b101 && funct7[5]);
					dec.writesRd = 1'b1;
				end
			end
			OPC_LUI: begin
				dec.instClass = LUI;
				dec.imm = immU;
				dec.writesRd = 1'b1;
			end
			OPC_AUIPC: begin
				dec.instClass = AUIPC;
				dec.imm = immU;
				dec.writesRd = 1'b1;
			end
			OPC_JAL: begin
				dec.instClass = JAL;
				dec.imm = immJ;
				dec.writesRd = 1'b1;
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					dec.instClass = JALR;
					dec.writesRd = 1'b1;
				end
			end
			OPC_BRANCH: begin
				if (funct3 != 3'b010 && funct3 != 3'b011) begin
					dec.instClass = BRANCH;
					dec.aluOp = branchOp(funct3);
					dec.imm = immB;
					dec.useImm = 1'b0;
				end
			end
			OPC_LOAD: begin
				if (funct3 == 3'b010) begin // LW only
					dec.instClass = LOAD;
					dec.writesRd = 1'b1;
				end
			end
			OPC_STORE: begin
				if (funct3 == 3'b010) begin // SW only
					dec.instClass = STORE;
					dec.imm = immS;
				end
			end
			OPC_SYSTEM: begin
				if (inst == INST_EBREAK)
					dec.instClass = HALT;
			end
			default: ;
		endcase
	end

endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import rvPkg::*; (
	input decodedInst_t dec,
	input logic [XLEN-1:0] rd1,
	input logic [XLEN-1:0] rd2,
	output aluResult_t alu
);

	logic [XLEN-1:0] opB;
	logic [4:0] shamt;

	assign opB = dec.useImm ? dec.imm : rd2;
	assign shamt = opB[4:0];

	always_comb begin
		alu.value = '0;
		alu.taken = 1'b0;
		if (dec.instClass == LUI) begin
			alu.value = dec.imm; // Shares the ALU write-back path
		end else begin
			case (dec.aluOp)
				ADD: alu.value = rd1 + opB;
				SUB: alu.value = rd1 - opB;
				SLL: alu.value = rd1 << shamt;
				SLT: alu.value = {{(XLEN-1){1'b0}}, $signed(rd1) < $signed(opB)};
				SLTU: alu.value = {{(XLEN-1){1'b0}}, rd1 < opB};
				XOR: alu.value = rd1 ^ opB;
				SRL: alu.value = rd1 >> shamt;
				SRA: alu.value = $unsigned($signed(rd1) >>> shamt);
				OR: alu.value = rd1 | opB;
				AND: alu.value = rd1 & opB;
				// Branches always compare the two registers
				BEQ: alu.taken = rd1 == rd2;
				BNE: alu.taken = rd1 != rd2;
				BLT: alu.taken = $signed(rd1) < $signed(rd2);
				BGE: alu.taken = $signed(rd1) >= $signed(rd2);
				BLTU: alu.taken = rd1 < rd2;
				BGEU: alu.taken = rd1 >= rd2;
				default: ;
			endcase
		end
	end

endmodule

// ==== logic/targetUnit.sv ====
`timescale 1ns/1ps

module targetUnit import rvPkg::*; (
	input decodedInst_t dec,
	input logic [ADDR_W-1:0] pc,
	input logic [XLEN-1:0] rd1,
	output pcTargets_t tgt
);

	logic [XLEN-1:0] jalrSum;

	assign jalrSum = rd1 + dec.imm;

	// All three run beside the ALU
	assign tgt.seqPc = pc + ADDR_W'(4);
	assign tgt.relPc = pc + dec.imm[ADDR_W-1:0]; // Branch, JAL and AUIPC low bits
	assign tgt.jalrPc = {jalrSum[ADDR_W-1:1], 1'b0};

endmodule

// ==== logic/commitUnit.sv ====
`timescale 1ns/1ps

module commitUnit import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input decodedInst_t dec,
	input aluResult_t alu,
	input pcTargets_t tgt,
	input logic [XLEN-1:0] memData,
	output logic [ADDR_W-1:0] pc,
	output logic rfWe,
	output logic [REG_W-1:0] rfWa,
	output logic [XLEN-1:0] rfWd,
	output logic halt,
	output logic [XLEN-1:0] numInst
);

	logic [ADDR_W-1:0] nextPc;

	assign halt = !RSTn && dec.instClass == HALT;
	assign rfWe = !RSTn && !halt && dec.writesRd && dec.rd != '0;
	assign rfWa = dec.rd;

	always_comb begin
		case (dec.instClass)
			JAL: nextPc = tgt.relPc;
			BRANCH: nextPc = alu.taken ? tgt.relPc : tgt.seqPc;
			JALR: nextPc = tgt.jalrPc;
			default: nextPc = tgt.seqPc;
		endcase
	end

	always_comb begin
		case (dec.instClass)
			LOAD: rfWd = memData;
			JAL, JALR: rfWd = {{(XLEN-ADDR_W){1'b0}}, tgt.seqPc};
			// Upper imm has zero low bits, so no carry out of relPc
			AUIPC: rfWd = {dec.imm[XLEN-1:ADDR_W], tgt.relPc};
			default: rfWd = alu.value;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
			numInst <= '0;
		end else if (!halt) begin
			pc <= nextPc;
			numInst <= numInst + 1; // One retire per cycle
		end
	end

	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00)
		else $error("PC 0x%03h not word aligned", pc);

	// Unknown words would silently retire as no-ops
	noIllegal: assert property (@(posedge CLK) disable iff (RSTn) dec.instClass != ILLEGAL)
		else $error("Illegal instruction at PC 0x%03h", pc);

endmodule

// ==== logic/rvTop.sv ====
`timescale 1ns/1ps

module rvTop import rvPkg::*; (
	input logic CLK,
	input logic RSTn,

	output logic I_MEM_CSN,
	input logic [31:0] I_MEM_DI,
	output logic [11:0] I_MEM_ADDR, // Byte address

	output logic D_MEM_CSN,
	input logic [31:0] D_MEM_DI,
	output logic [31:0] D_MEM_DOUT,
	output logic [11:0] D_MEM_ADDR, // Word address
	output logic D_MEM_WEN,
	output logic [3:0] D_MEM_BE,

	output logic RF_WE,
	output logic [4:0] RF_RA1,
	output logic [4:0] RF_RA2,
	output logic [4:0] RF_WA1,
	input logic [31:0] RF_RD1,
	input logic [31:0] RF_RD2,
	output logic [31:0] RF_WD,
	output logic HALT,
	output logic [31:0] NUM_INST,
	output logic [31:0] OUTPUT_PORT
);

	decodedInst_t dec;
	aluResult_t alu;
	pcTargets_t tgt;
	logic memAccess;

	instDecoder decoder (
		.inst(I_MEM_DI),
		.dec(dec)
	);

	assign RF_RA1 = dec.rs1;
	assign RF_RA2 = dec.rs2;

	aluUnit aluBlk (
		.dec(dec),
		.rd1(RF_RD1),
		.rd2(RF_RD2),
		.alu(alu)
	);

	targetUnit targets (
		.dec(dec),
		.pc(I_MEM_ADDR),
		.rd1(RF_RD1),
		.tgt(tgt)
	);

	commitUnit commit (
		.CLK(CLK),
		.RSTn(RSTn),
		.dec(dec),
		.alu(alu),
		.tgt(tgt),
		.memData(D_MEM_DI),
		.pc(I_MEM_ADDR),
		.rfWe(RF_WE),
		.rfWa(RF_WA1),
		.rfWd(RF_WD),
		.halt(HALT),
		.numInst(NUM_INST)
	);

	assign memAccess = dec.instClass == LOAD || dec.instClass == STORE;

	assign I_MEM_CSN = RSTn;
	assign D_MEM_CSN = RSTn || !memAccess;
	assign D_MEM_WEN = RSTn || dec.instClass != STORE; // Active low
	assign D_MEM_ADDR = alu.value[ADDR_W+1:2];
	assign D_MEM_DOUT = RF_RD2;
	assign D_MEM_BE = 4'b1111; // Word accesses only

	assign OUTPUT_PORT = RF_WD;

endmodule

// ==== bench/rvModel.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// Architectural state of the reference model
logic [31:0] mRegs [32];
logic [31:0] mMem [4096];
logic [31:0] mPc;
int mCount;

// Executes one instruction on the model state and returns what the core should show
function automatic void modelStep(input logic [31:0] inst, output logic we,
		output logic [4:0] wa, output logic [31:0] wd, output logic load,
		output logic store, output logic [11:0] memIdx, output logic [31:0] memWd,
		output logic halted);
	logic [31:0] a, b, immI, immS, immB, immJ, addr, res, nextPc;
	logic [2:0] f3;
	logic wr, cond;
	a = mRegs[inst[19:15]];
	b = mRegs[inst[24:20]];
	f3 = inst[14:12];
	immI = {{20{inst[31]}}, inst[31:20]};
	immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	res = 32'd0;
	wr = 1'b0;
	cond = 1'b0;
	load = 1'b0;
	store = 1'b0;
	memIdx = 12'd0;
	memWd = 32'd0;
	halted = 1'b0;
	nextPc = mPc + 32'd4;
	case (inst[6:0])
		7'b0110011, 7'b0010011: begin
			if (inst[5] == 1'b0)
				b = immI; // OP-IMM
			wr = 1'b1;
			case (f3)
				3'd0: res = (inst[5] && inst[30]) ? a - b : a + b;
				3'd1: res = a << b[4:0];
				3'd2: res = {31'd0, $signed(a) < $signed(b)};
				3'd3: res = {31'd0, a < b};
				3'd4: res = a ^ b;
				3'd5: res = inst[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
				3'd6: res = a | b;
				default: res = a & b;
			endcase
		end
		7'b0110111: begin
			res = {inst[31:12], 12'd0};
			wr = 1'b1;
		end
		7'b0010111: begin
			res = mPc + {inst[31:12], 12'd0};
			wr = 1'b1;
		end
		7'b1101111: begin
			res = mPc + 32'd4;
			nextPc = mPc + immJ;
			wr = 1'b1;
		end
		7'b1100111: begin
			res = mPc + 32'd4;
			nextPc = (a + immI) & ~32'd1;
			wr = 1'b1;
		end
		7'b1100011: begin
			case (f3)
				3'd0: cond = a == b;
				3'd1: cond = a != b;
				3'd4: cond = $signed(a) < $signed(b);
				3'd5: cond = $signed(a) >= $signed(b);
				3'd6: cond = a < b;
				default: cond = a >= b;
			endcase
			if (cond)
				nextPc = mPc + immB;
		end
		7'b0000011: begin
			addr = a + immI;
			memIdx = addr[13:2]; // Word-addressed memory
			res = mMem[memIdx];
			load = 1'b1;
			wr = 1'b1;
		end
		7'b0100011: begin
			addr = a + immS;
			memIdx = addr[13:2];
			memWd = b;
			mMem[memIdx] = b;
			store = 1'b1;
		end
		7'b1110011: begin
			halted = 1'b1;
			nextPc = mPc;
		end
		default: ;
	endcase
	wa = inst[11:7];
	we = wr && wa != 5'd0;
	wd = res;
	if (we)
		mRegs[wa] = res;
	if (!halted)
		mCount++;
	mPc = nextPc;
endfunction

`endif

// ==== bench/rvTb.sv ====
`timescale 1ns/1ps

module rvTb;

	localparam int PROG_LEN = 200;
	localparam int RESET_CYCLES = 10;
	localparam int CLK_PERIOD = 40;
	localparam int TIMEOUT_NS = (PROG_LEN + 20 + RESET_CYCLES) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hcf1b_e520;
	localparam logic [31:0] EBREAK = 32'h0010_0073;

	logic CLK, RSTn;
	logic I_MEM_CSN, D_MEM_CSN, D_MEM_WEN, RF_WE, HALT;
	logic [31:0] I_MEM_DI, D_MEM_DI, D_MEM_DOUT, RF_RD1, RF_RD2, RF_WD;
	logic [31:0] NUM_INST, OUTPUT_PORT;
	logic [11:0] I_MEM_ADDR, D_MEM_ADDR;
	logic [3:0] D_MEM_BE;
	logic [4:0] RF_RA1, RF_RA2, RF_WA1;

	logic [31:0] imem [1024];
	logic [31:0] dmem [4096];
	logic [31:0] regs [32];

	`include "rvModel.svh"

	rvTop dut_i (.*);

	// Asynchronous reads
	assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
	assign D_MEM_DI = dmem[D_MEM_ADDR];
	assign RF_RD1 = regs[RF_RA1];
	assign RF_RD2 = regs[RF_RA2];

	always @(posedge CLK) begin
		if (RF_WE && RF_WA1 != 5'd0)
			regs[RF_WA1] <= RF_WD;
		if (!D_MEM_CSN && !D_MEM_WEN)
			dmem[D_MEM_ADDR] <= D_MEM_DOUT;
	end

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic buildProgram();
		int i;
		int t;
		logic [31:0] r, imm, off, jumpTo;
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		for (i = 0; i < 1024; i++)
			imem[i] = EBREAK; // Anything past the program halts
		i = 0;
		while (i < PROG_LEN - 1) begin
			r = $urandom;
			imm = $urandom;
			rd = r[4:0];
			rs1 = r[9:5];
			rs2 = r[14:10];
			f3 = r[17:15];
			f7 = (r[18] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
			t = i + 1 + int'(r[21:19]); // Forward by 1 to 8
			if (t > PROG_LEN - 1)
				t = PROG_LEN - 1;
			off = (t - i) * 4;
			jumpTo = t * 4 + int'(r[22]); // Odd on half the JALRs
			case ($urandom % 10)
				0, 1: imem[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
				2, 3: imem[i] = {(f3 == 3'd1 || f3 == 3'd5) ? {f7, imm[4:0]} : imm[11:0],
					rs1, f3, rd, 7'b0010011};
				4: imem[i] = {imm[31:12], rd, 7'b0110111};
				5: imem[i] = {imm[31:12], rd, 7'b0010111};
				6: begin
					if (r[23])
						rs2 = rs1; // Equal operands
					if (f3 == 3'd2 || f3 == 3'd3)
						f3 = f3 + 3'd2;
					imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
				end
				7: imem[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
				8: imem[i] = {jumpTo[11:0], 5'd0, 3'b000, rd, 7'b1100111};
				default: begin
					// SW, then LW of the same word
					imem[i] = {2'b00, imm[7:3], rs2, 5'd0, 3'b010, imm[2:0], 2'b00, 7'b0100011};
					if (i < PROG_LEN - 2) begin
						i++;
						imem[i] = {2'b00, imm[7:0], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
					end
				end
			endcase
			i++;
		end
	endtask

	initial begin
		logic [31:0] v;
		int i;
		RSTn = 1'b1;
		v = $urandom(SEED);
		buildProgram();
		for (i = 0; i < 32; i++) begin
			v = (i == 0) ? 32'd0 : $urandom;
			regs[i] <= v;
			mRegs[i] = v;
		end
		for (i = 0; i < 4096; i++) begin
			v = {i[11:0], 8'h5a, ~i[11:0]};
			dmem[i] <= v;
			mMem[i] = v;
		end
		mPc = 32'd0;
		mCount = 0;
		repeat (RESET_CYCLES - 1) @(posedge CLK);
		@(negedge CLK);
		checkValue("I_MEM_ADDR", 32'(I_MEM_ADDR), 32'd0);
		checkValue("NUM_INST", NUM_INST, 32'd0);
		checkValue("RF_WE", 32'(RF_WE), 32'd0);
		checkValue("HALT", 32'(HALT), 32'd0);
		checkValue("I_MEM_CSN", 32'(I_MEM_CSN), 32'd1);
		checkValue("D_MEM_CSN", 32'(D_MEM_CSN), 32'd1);
		checkValue("D_MEM_WEN", 32'(D_MEM_WEN), 32'd1);
		@(posedge CLK);
		#1 RSTn = 1'b0;
	end

	// Mid-cycle compare against the model
	always @(negedge CLK) begin
		logic [31:0] inst;
		logic expWe, expLoad, expStore, expHalt;
		logic [4:0] expWa;
		logic [11:0] expIdx;
		logic [31:0] expWd, expSd;
		if (!RSTn) begin
			checkValue("I_MEM_ADDR", 32'(I_MEM_ADDR), mPc);
			checkValue("I_MEM_CSN", 32'(I_MEM_CSN), 32'd0);
			inst = imem[mPc[11:2]];
			checkValue("RF_RA1", 32'(RF_RA1), 32'(inst[19:15]));
			checkValue("RF_RA2", 32'(RF_RA2), 32'(inst[24:20]));
			modelStep(inst, expWe, expWa, expWd, expLoad, expStore, expIdx, expSd, expHalt);
			checkValue("RF_WE", 32'(RF_WE), 32'(expWe));
			if (expWe) begin
				checkValue("RF_WA1", 32'(RF_WA1), 32'(expWa));
				checkValue("RF_WD", RF_WD, expWd);
				checkValue("OUTPUT_PORT", OUTPUT_PORT, expWd);
			end
			checkValue("D_MEM_CSN", 32'(D_MEM_CSN), 32'(!(expLoad || expStore)));
			checkValue("D_MEM_WEN", 32'(D_MEM_WEN), 32'(!expStore));
			if (expLoad || expStore) begin
				checkValue("D_MEM_ADDR", 32'(D_MEM_ADDR), 32'(expIdx));
				checkValue("D_MEM_BE", 32'(D_MEM_BE), 32'hf);
			end
			if (expStore)
				checkValue("D_MEM_DOUT", D_MEM_DOUT, expSd);
			checkValue("HALT", 32'(HALT), 32'(expHalt));
			if (expHalt) begin
				checkValue("NUM_INST", NUM_INST, 32'(mCount));
				checkValue("I_MEM_ADDR", 32'(I_MEM_ADDR), 32'((PROG_LEN - 1) * 4));
				$display("STATUS: PASS");
				$finish;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog timeout: HALT never rose within %0d ns", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$fatal(1, "Timeout");
	end

endmodule

// ==== vlog.f ====
+incdir+bench
common/rvPkg.sv
logic/instDecoder.sv
logic/aluUnit.sv
logic/targetUnit.sv
logic/commitUnit.sv
logic/rvTop.sv
bench/rvTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds rvTb with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --assert --top-module rvTb -Mdir "$BUILD_DIR" -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/VrvTb" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "STATUS: PASS" "$LOG_FILE"; then
	echo "Run passed"
	exit 0
else
	echo "Run failed"
	exit 1
fi
